/* src.f */
design/trap_pkg.sv
design/csr_pkg.sv
design/machine_csr_file.sv
design/trap_sequencer.sv
design/trap_unit_top.sv
tb/trap_unit_tb.sv

/* Bender.yml */
package:
  name: trap_unit

sources:
  - design/trap_pkg.sv
  - design/csr_pkg.sv
  - design/machine_csr_file.sv
  - design/trap_sequencer.sv
  - design/trap_unit_top.sv
  - target: test
    files:
      - tb/trap_unit_tb.sv

/* tb/trap_unit_tb.sv */
////////////////////////////////////////
// host port used only between cases while the DUT idles
////////////////////////////////////////

`timescale 1ns/100ps

module trap_unit_tb;

  localparam int num_cases   = 8;
  localparam int case_cycles = 80;   // generous bound per row
  localparam logic [63:0] cause_marker = 64'h0000_00a5_0000_005a;

  logic                     clk = 1'b0;
  logic                     rst = 1'b1;
  logic                     i_ena = 1'b0;
  logic [7:0]               i_opcode = '0;
  logic [csr_pkg::xlen-1:0] i_pc = '0;
  logic                     i_ack = 1'b0;
  logic                     i_host_wen = 1'b0;
  logic [11:0]              i_host_addr = '0;
  logic [csr_pkg::xlen-1:0] i_host_wdata = '0;
  logic                     o_req;
  logic                     o_pc_jmp;
  logic [csr_pkg::xlen-1:0] o_pc_jmpaddr;
  logic [csr_pkg::xlen-1:0] o_host_rdata;

  // case table
  logic [7:0]  t_opcode   [num_cases];
  logic [63:0] t_pc       [num_cases];
  logic [63:0] t_mtvec    [num_cases];
  logic [63:0] t_mstatus  [num_cases];
  logic [63:0] t_mepc_pre [num_cases];
  int          t_hold     [num_cases];
  logic [63:0] t_jmp      [num_cases];
  logic [63:0] t_mcause   [num_cases];
  logic [63:0] t_mepc     [num_cases];
  logic [63:0] t_status   [num_cases];

  integer seed = 98914;

  trap_unit_top dut_i (
    .clk (clk), .rst (rst), .i_ena (i_ena), .i_opcode (i_opcode), .i_pc (i_pc),
    .i_ack (i_ack), .o_req (o_req), .o_pc_jmp (o_pc_jmp), .o_pc_jmpaddr (o_pc_jmpaddr),
    .i_host_wen (i_host_wen), .i_host_addr (i_host_addr), .i_host_wdata (i_host_wdata),
    .o_host_rdata (o_host_rdata)
  );

  always #50 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  // mpp to 11, mpie from mie, mie cleared
  function automatic logic [63:0] entry_status(input logic [63:0] old);
    csr_pkg::mstatus_u u;
    csr_pkg::mstatus_u n;
    u.raw = old;
    n = u;
    n.f.mpp  = 2'b11;
    n.f.mpie = u.f.mie;
    n.f.mie  = 1'b0;
    return n.raw;
  endfunction

  // mie from mpie, mpie set, mpp to 00
  function automatic logic [63:0] return_status(input logic [63:0] old);
    csr_pkg::mstatus_u u;
    csr_pkg::mstatus_u n;
    u.raw = old;
    n = u;
    n.f.mie  = u.f.mpie;
    n.f.mpie = 1'b1;
    n.f.mpp  = 2'b00;
    return n.raw;
  endfunction

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic add_row(input int i, input logic [7:0] op, input logic [63:0] pc,
                         input logic [63:0] mtvec, input logic [63:0] mstatus, input int hold);
    t_opcode[i] = op;
    t_pc[i]     = pc;
    t_mtvec[i]  = mtvec;
    t_mstatus[i] = mstatus;
    t_hold[i]   = hold;
    if (op == trap_pkg::op_mret) begin
      t_mepc_pre[i] = pc;             // return target comes from mepc
      t_jmp[i]      = pc;
      t_mcause[i]   = cause_marker;
      t_mepc[i]     = pc;
      t_status[i]   = return_status(mstatus);
    end else begin
      t_mepc_pre[i] = ~pc;            // so the mepc write is visible
      t_jmp[i]      = {mtvec[63:2], 2'b00};
      t_mcause[i]   = (op == trap_pkg::op_ecall) ? trap_pkg::cause_ecall_m
                                                 : trap_pkg::cause_timer_m;
      t_mepc[i]     = pc;
      t_status[i]   = entry_status(mstatus);
    end
  endtask

  task automatic fill_table();
    add_row(0, trap_pkg::op_ecall, 64'h8000_0000_0000_1000, 64'h0000_0000_8000_0103,
            64'h0000_0000_0000_0008, 0);
    add_row(1, trap_pkg::op_ecall, rand64(), rand64(), rand64() & ~64'h8, 2);
    add_row(2, 8'h01, rand64(), rand64() | 64'h2, rand64() | 64'h8, 3);
    add_row(3, 8'hff, rand64(), rand64(), 64'h0, 1);
    add_row(4, trap_pkg::op_mret, rand64(), rand64(), rand64() | 64'h80, 0);
    add_row(5, trap_pkg::op_mret, rand64(), rand64(), rand64() & ~64'h80, 4);
    add_row(6, trap_pkg::op_ecall, rand64(), rand64(), rand64(), 5);
    add_row(7, trap_pkg::op_mret, rand64(), rand64(), 64'hffff_ffff_ffff_ff7f, 2);
  endtask

  task automatic host_write(input logic [11:0] addr, input logic [63:0] data);
    @(posedge clk);
    i_host_wen   <= 1'b1;
    i_host_addr  <= addr;
    i_host_wdata <= data;
    @(posedge clk);
    i_host_wen   <= 1'b0;
  endtask

  task automatic host_expect(input string name, input logic [11:0] addr,
                             input logic [63:0] exp);
    @(posedge clk);
    i_host_addr <= addr;
    @(negedge clk);
    check_value(name, o_host_rdata, exp);
  endtask

  task automatic run_case(input int i);
    int k;
    host_write(csr_pkg::csr_mtvec, t_mtvec[i]);
    host_write(csr_pkg::csr_mstatus, t_mstatus[i]);
    host_write(csr_pkg::csr_mepc, t_mepc_pre[i]);
    host_write(csr_pkg::csr_mcause, cause_marker);
    @(posedge clk);
    i_ena    <= 1'b1;
    i_opcode <= t_opcode[i];
    i_pc     <= t_pc[i];
    @(posedge clk);
    i_ena    <= 1'b0;
    i_opcode <= (t_opcode[i] == trap_pkg::op_ecall) ? 8'h01 : trap_pkg::op_ecall;
    i_pc     <= ~t_pc[i];             // only the captured copies count now
    @(negedge clk);
    while (!o_req) @(negedge clk);
    check_value("o_pc_jmp", o_pc_jmp, 1'b1);
    check_value("o_pc_jmpaddr", o_pc_jmpaddr, t_jmp[i]);
    for (k = 0; k < t_hold[i]; k++) begin
      @(posedge clk);
      i_ena    <= (k == 0);           // must not start a new sequence
      i_opcode <= trap_pkg::op_ecall;
      i_pc     <= ~t_pc[i];
      @(negedge clk);
      check_value("o_req", o_req, 1'b1);
      check_value("o_pc_jmp", o_pc_jmp, 1'b1);
      check_value("o_pc_jmpaddr", o_pc_jmpaddr, t_jmp[i]);
    end
    @(posedge clk);
    i_ena <= 1'b0;
    i_ack <= 1'b1;
    @(posedge clk);
    i_ack <= 1'b0;
    @(negedge clk);
    check_value("o_req", o_req, 1'b0);
    check_value("o_pc_jmp", o_pc_jmp, 1'b0);
    check_value("o_pc_jmpaddr", o_pc_jmpaddr, '0);
    host_expect("mepc", csr_pkg::csr_mepc, t_mepc[i]);
    host_expect("mcause", csr_pkg::csr_mcause, t_mcause[i]);
    host_expect("mstatus", csr_pkg::csr_mstatus, t_status[i]);
  endtask

  // watchdog
  initial begin
    #((num_cases * case_cycles + 40) * 100);
    $display("timeout, the DUT never finished its request sequence");
    $display("STATUS: FAIL");
    $fatal(1);
  end

  initial begin
    fill_table();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("o_req", o_req, 1'b0);
    check_value("o_pc_jmp", o_pc_jmp, 1'b0);
    check_value("o_pc_jmpaddr", o_pc_jmpaddr, '0);
    host_expect("mepc", csr_pkg::csr_mepc, '0);
    host_expect("mcause", csr_pkg::csr_mcause, '0);
    host_expect("mtvec", csr_pkg::csr_mtvec, '0);
    host_expect("mstatus", csr_pkg::csr_mstatus, '0);
    for (int i = 0; i < num_cases; i++) begin
      run_case(i);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* design/trap_unit_top.sv */
////////////////////////////////////////
// host port only while o_req low and idle
////////////////////////////////////////

`timescale 1ns/100ps

module trap_unit_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_ena,
  input  logic [7:0]               i_opcode,
  input  logic [csr_pkg::xlen-1:0] i_pc,
  input  logic                     i_ack,
  output logic                     o_req,
  output logic                     o_pc_jmp,
  output logic [csr_pkg::xlen-1:0] o_pc_jmpaddr,
  input  logic                     i_host_wen,
  input  logic [11:0]              i_host_addr,
  input  logic [csr_pkg::xlen-1:0] i_host_wdata,
  output logic [csr_pkg::xlen-1:0] o_host_rdata
);

  // sequencer to csr file
  logic [11:0]              csr_addr;
  logic                     csr_ren;
  logic                     csr_wen;
  logic [csr_pkg::xlen-1:0] csr_wdata;
  logic [csr_pkg::xlen-1:0] csr_rdata;

  trap_sequencer seq_i (
    .clk          (clk),
    .rst          (rst),
    .i_ena        (i_ena),
    .i_opcode     (i_opcode),
    .i_pc         (i_pc),
    .i_ack        (i_ack),
    .o_req        (o_req),
    .o_pc_jmp     (o_pc_jmp),
    .o_pc_jmpaddr (o_pc_jmpaddr),
    .i_csr_rdata  (csr_rdata),
    .o_csr_addr   (csr_addr),
    .o_csr_ren    (csr_ren),
    .o_csr_wen    (csr_wen),
    .o_csr_wdata  (csr_wdata)
  );

  machine_csr_file csr_i (
    .clk          (clk),
    .rst          (rst),
    .i_addr       (csr_addr),
    .i_ren        (csr_ren),
    .i_wen        (csr_wen),
    .i_wdata      (csr_wdata),
    .o_rdata      (csr_rdata),
    .i_host_wen   (i_host_wen),
    .i_host_addr  (i_host_addr),
    .i_host_wdata (i_host_wdata),
    .o_host_rdata (o_host_rdata)
  );

endmodule

/* design/trap_sequencer.sv */
////////////////////////////////////////
// csr steps take 3 cycles each
// req holds until ack and i_ena is ignored meanwhile
////////////////////////////////////////

`timescale 1ns/100ps

module trap_sequencer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_ena,
  input  logic [7:0]               i_opcode,
  input  logic [csr_pkg::xlen-1:0] i_pc,
  input  logic                     i_ack,
  output logic                     o_req,
  output logic                     o_pc_jmp,
  output logic [csr_pkg::xlen-1:0] o_pc_jmpaddr,
  input  logic [csr_pkg::xlen-1:0] i_csr_rdata,
  output logic [11:0]              o_csr_addr,
  output logic                     o_csr_ren,
  output logic                     o_csr_wen,
  output logic [csr_pkg::xlen-1:0] o_csr_wdata
);

  logic [3:0] state;
  logic [1:0] step;

  // captured in idle since the inputs last a single cycle
  logic [csr_pkg::xlen-1:0] pc_save;
  logic [csr_pkg::xlen-1:0] cause_save;

  logic [csr_pkg::xlen-1:0] target_save;  // mtvec or mepc
  csr_pkg::mstatus_u        mstatus_old;
  csr_pkg::mstatus_u        mstatus_new;

  // per-state step decode
  logic                     step_rd;
  logic                     step_wr;
  logic [11:0]              step_addr;
  logic [csr_pkg::xlen-1:0] step_wdata;
  logic [3:0]               step_next;
  logic                     step_last;

  always_comb begin
    mstatus_new = mstatus_old;
    if (state == trap_pkg::st_enter_wr_mstatus) begin
      mstatus_new.f.mpp  = 2'b11;               // trap into m-mode
      mstatus_new.f.mpie = mstatus_old.f.mie;
      mstatus_new.f.mie  = 1'b0;
    end else begin
      mstatus_new.f.mie  = mstatus_old.f.mpie;
      mstatus_new.f.mpie = 1'b1;
      mstatus_new.f.mpp  = 2'b00;
    end
  end

  always_comb begin
    step_rd    = 1'b0;
    step_wr    = 1'b0;
    step_addr  = '0;
    step_wdata = '0;
    step_next  = trap_pkg::st_idle;
    step_last  = 1'b0;
    case (state)
      trap_pkg::st_enter_wr_mepc: begin
        step_wr    = 1'b1;
        step_addr  = csr_pkg::csr_mepc;
        step_wdata = pc_save;
        step_next  = trap_pkg::st_enter_wr_mcause;
      end
      trap_pkg::st_enter_wr_mcause: begin
        step_wr    = 1'b1;
        step_addr  = csr_pkg::csr_mcause;
        step_wdata = cause_save;
        step_next  = trap_pkg::st_enter_rd_mtvec;
      end
      trap_pkg::st_enter_rd_mtvec: begin
        step_rd   = 1'b1;
        step_addr = csr_pkg::csr_mtvec;
        step_next = trap_pkg::st_enter_rd_mstatus;
      end
      trap_pkg::st_enter_rd_mstatus: begin
        step_rd   = 1'b1;
        step_addr = csr_pkg::csr_mstatus;
        step_next = trap_pkg::st_enter_wr_mstatus;
      end
      trap_pkg::st_enter_wr_mstatus,
      trap_pkg::st_leave_wr_mstatus: begin
        step_wr    = 1'b1;
        step_addr  = csr_pkg::csr_mstatus;
        step_wdata = mstatus_new.raw;
        step_last  = 1'b1;
      end
      trap_pkg::st_leave_rd_mstatus: begin
        step_rd   = 1'b1;
        step_addr = csr_pkg::csr_mstatus;
        step_next = trap_pkg::st_leave_rd_mepc;
      end
      trap_pkg::st_leave_rd_mepc: begin
        step_rd   = 1'b1;
        step_addr = csr_pkg::csr_mepc;
        step_next = trap_pkg::st_leave_wr_mstatus;
      end
      default: ;
    endcase
  end

  // strobes only in the issue step
  assign o_csr_addr  = step_addr;
  assign o_csr_ren   = step_rd & (step == 2'd0);
  assign o_csr_wen   = step_wr & (step == 2'd0);
  assign o_csr_wdata = step_wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= trap_pkg::st_idle;
      step         <= 2'd0;
      o_req        <= 1'b0;
      o_pc_jmp     <= 1'b0;
      o_pc_jmpaddr <= '0;
    end else begin
      if (o_req && i_ack) begin
        o_req        <= 1'b0;
        o_pc_jmp     <= 1'b0;
        o_pc_jmpaddr <= '0;
      end
      if (state == trap_pkg::st_idle) begin
        step <= 2'd0;
        if (i_ena && !o_req) begin  // no start while a jump is pending
          if (i_opcode == trap_pkg::op_mret) begin
            state <= trap_pkg::st_leave_rd_mstatus;
          end else begin
            state <= trap_pkg::st_enter_wr_mepc;
          end
        end
      end else begin
        case (step)
          2'd0: step <= 2'd1;
          2'd1: step <= 2'd2;
          2'd2: begin
            step  <= 2'd0;
            state <= step_next;
            if (step_last) begin
              o_req        <= 1'b1;
              o_pc_jmp     <= 1'b1;
              o_pc_jmpaddr <= target_save;
            end
          end
          default: step <= 2'd0;
        endcase
      end
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    if (state == trap_pkg::st_idle && i_ena && !o_req) begin
      pc_save <= i_pc;
      if (i_opcode == trap_pkg::op_ecall) begin
        cause_save <= trap_pkg::cause_ecall_m;
      end else begin
        cause_save <= trap_pkg::cause_timer_m;
      end
    end
    if (step == 2'd1 && step_rd) begin  // read data lands one cycle after issue
      if (step_addr == csr_pkg::csr_mstatus) begin
        mstatus_old.raw <= i_csr_rdata;
      end else begin
        target_save <= i_csr_rdata;
      end
    end
  end

endmodule

/* design/machine_csr_file.sv */
////////////////////////////////////////
// sequencer write wins over a host write
// mtvec is direct mode only
////////////////////////////////////////

`timescale 1ns/100ps

module machine_csr_file (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [11:0]              i_addr,
  input  logic                     i_ren,
  input  logic                     i_wen,
  input  logic [csr_pkg::xlen-1:0] i_wdata,
  output logic [csr_pkg::xlen-1:0] o_rdata,
  input  logic                     i_host_wen,
  input  logic [11:0]              i_host_addr,
  input  logic [csr_pkg::xlen-1:0] i_host_wdata,
  output logic [csr_pkg::xlen-1:0] o_host_rdata
);

  logic [csr_pkg::xlen-1:0] mepc_q;
  logic [csr_pkg::xlen-1:0] mcause_q;
  logic [csr_pkg::xlen-1:0] mtvec_q;
  logic [csr_pkg::xlen-1:0] mstatus_q;

  logic                     wr_en;
  logic [11:0]              wr_addr;
  logic [csr_pkg::xlen-1:0] wr_data;

  // unknown addresses read as zero
  function automatic logic [csr_pkg::xlen-1:0] read_csr(input logic [11:0] addr);
    case (addr)
      csr_pkg::csr_mstatus: return mstatus_q;
      csr_pkg::csr_mtvec:   return mtvec_q;
      csr_pkg::csr_mepc:    return mepc_q;
      csr_pkg::csr_mcause:  return mcause_q;
      default:              return '0;
    endcase
  endfunction

  // one write port shared by both masters
  assign wr_en   = i_wen | i_host_wen;
  assign wr_addr = i_wen ? i_addr : i_host_addr;
  assign wr_data = i_wen ? i_wdata : i_host_wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      mepc_q    <= '0;
      mcause_q  <= '0;
      mtvec_q   <= '0;
      mstatus_q <= '0;
    end else if (wr_en) begin
      case (wr_addr)
        csr_pkg::csr_mstatus: mstatus_q <= wr_data;
        csr_pkg::csr_mtvec:   mtvec_q   <= {wr_data[csr_pkg::xlen-1:2], 2'b00}; // mode bits
        csr_pkg::csr_mepc:    mepc_q    <= wr_data;
        csr_pkg::csr_mcause:  mcause_q  <= wr_data;
        default: ;
      endcase
    end
  end

  // sequencer read data valid the cycle after i_ren
  always_ff @(posedge clk) begin
    if (i_ren) begin
      o_rdata <= read_csr(i_addr);
    end
  end

  always_comb begin
    o_host_rdata = read_csr(i_host_addr);
  end

endmodule

/* design/csr_pkg.sv */
////////////////////////////////////////
// rv64 machine csr subset only
////////////////////////////////////////

package csr_pkg;

  localparam int xlen = 64;

  // machine csr addresses
  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  // mstatus seen either as a raw word or by the trap fields
  typedef union packed {
    logic [xlen-1:0] raw;
    struct packed {
      logic [50:0] upper;   // 63:13
      logic [1:0]  mpp;     // 12:11
      logic [2:0]  mid;     // 10:8
      logic        mpie;    // 7
      logic [2:0]  low_mid; // 6:4
      logic        mie;     // 3
      logic [2:0]  low;     // 2:0
    } f;
  } mstatus_u;

endpackage

/* design/trap_pkg.sv */
////////////////////////////////////////
// opcode codes are local to this core, not ISA encodings
// any other code with the enable strobe means timer irq
////////////////////////////////////////

package trap_pkg;

  // opcode byte presented with i_ena
  localparam logic [7:0] op_ecall = 8'h73;
  localparam logic [7:0] op_mret  = 8'h30;

  // mcause values written on trap entry
  localparam logic [63:0] cause_ecall_m = 64'd11;
  localparam logic [63:0] cause_timer_m = {1'b1, 63'd7}; // interrupt bit set

  // sequencer states
  localparam logic [3:0] st_idle             = 4'd0;

  // entry path for ecall or timer
  localparam logic [3:0] st_enter_wr_mepc    = 4'd1;
  localparam logic [3:0] st_enter_wr_mcause  = 4'd2;
  localparam logic [3:0] st_enter_rd_mtvec   = 4'd3;
  localparam logic [3:0] st_enter_rd_mstatus = 4'd4;
  localparam logic [3:0] st_enter_wr_mstatus = 4'd5;

  // return path for mret
  localparam logic [3:0] st_leave_rd_mstatus = 4'd6;
  localparam logic [3:0] st_leave_rd_mepc    = 4'd7;
  localparam logic [3:0] st_leave_wr_mstatus = 4'd8;

endpackage
